/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= nonblocking_cache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* cache_assert.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_assert (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  mem_ren,
    input logic                  mem_wen,
    input logic [`ADDR_BITS-1:0] mem_addr,
    input logic                  mem_done,
    input logic                  done_valid
);

    // The shared port carries either a read or a write, never both.
    read_write_exclusive: assert property (
        @(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen)
    ) else $error("mem_ren and mem_wen high together");

    // An open memory access keeps its address until the memory completes it.
    addr_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((mem_ren || mem_wen) && !mem_done) |=> $stable(mem_addr)
    ) else $error("mem_addr changed before mem_done");

    done_single_pulse: assert property (
        @(posedge CLK) disable iff (!nRST) done_valid |=> !done_valid
    ) else $error("done_valid held longer than one cycle");

endmodule

bind nonblocking_cache cache_assert u_assert (
    .CLK        (CLK),
    .nRST       (nRST),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_addr   (mem_addr),
    .mem_done   (mem_done),
    .done_valid (done_valid)
);

/* cache_bank.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_bank
    import cache_types_pkg::*;
    import mem_req_pkg::*;
#(
    parameter int BANK_ID = 0
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    input  cache_req_t            req,
    mshr_if.bank                  mshr,
    ram_if.client                 ram,
    output logic                  hit,
    output logic                  merge_ok,
    output logic                  alloc,
    output logic [`WORD_BITS-1:0] load_data,
    output logic                  done_valid,
    output completion_t           done
);

    localparam logic [`BANK_BITS-1:0] BANK_SEL  = BANK_ID[`BANK_BITS-1:0];
    localparam logic [`OFF_BITS-1:0]  LAST_WORD = {`OFF_BITS{1'b1}};

    bank_fsm_e                               state, next_state;
    cache_set [`SETS_PER_BANK-1:0]           sets, next_sets;
    lru_frame [`SETS_PER_BANK-1:0]           lru, next_lru;
    logic [`OFF_BITS-1:0]                    count;
    logic [`SET_BITS-1:0]                    req_set, miss_set, victim_set;
    logic [`WAY_BITS-1:0]                    hit_way, victim_way;
    logic [`BLOCK_WORDS-1:0][`WORD_BITS-1:0] pull_buf;
    cache_frame                              eject_buf;
    logic                                    lookup_hit, pending_blk, fill_start, last_done;

    assign req_set    = req.addr.cache_view.index;
    assign miss_set   = mshr.entry.block_addr.cache_view.index;
    assign fill_start = (state == START) && mshr.entry.valid;
    assign last_done  = ram.complete && (count == LAST_WORD);

    // The way being victimized in START is hidden so a late store cannot escape the eject copy.
    always_comb begin
        lookup_hit = 1'b0;
        hit_way    = '0;
        for (int w = 0; w < `NUM_WAYS; w++) begin
            if (sets[req_set][w].valid && (sets[req_set][w].tag == req.addr.cache_view.tag) &&
                !(fill_start && (req_set == miss_set) &&
                  (w[`WAY_BITS-1:0] == lru[miss_set].lru_way))) begin
                lookup_hit = 1'b1;
                hit_way    = w[`WAY_BITS-1:0];
            end
        end
    end

    // Merging is refused in FINISH because the entry is freed at that edge.
    assign pending_blk = mshr.entry.valid && (state != FINISH) &&
                         (mshr.entry.block_addr.cache_view.tag == req.addr.cache_view.tag) &&
                         (miss_set == req_set);

    assign hit      = req_valid && lookup_hit;
    assign alloc    = req_valid && !lookup_hit && !mshr.entry.valid;
    assign merge_ok = req_valid && req.store && !lookup_hit && (pending_blk || !mshr.entry.valid);
    assign load_data = (hit && !req.store) ?
                       sets[req_set][hit_way].block[req.addr.cache_view.offset] : '0;

    always_comb begin
        next_sets = sets;
        if (hit && req.store) begin
            next_sets[req_set][hit_way].block[req.addr.cache_view.offset] = req.wdata;
            next_sets[req_set][hit_way].dirty = 1'b1;
        end
        if (fill_start) begin
            next_sets[miss_set][lru[miss_set].lru_way].valid = 1'b0;
        end
        if (state == FINISH) begin
            for (int k = 0; k < `BLOCK_WORDS; k++) begin
                next_sets[victim_set][victim_way].block[k] = mshr.entry.write_status[k] ?
                    mshr.entry.write_block[k] : pull_buf[k];
            end
            next_sets[victim_set][victim_way].valid = 1'b1;
            next_sets[victim_set][victim_way].dirty = |mshr.entry.write_status;
            next_sets[victim_set][victim_way].tag   = mshr.entry.block_addr.cache_view.tag;
        end
    end

    // Ages saturate. Ties go to the lowest way.
    always_comb begin
        logic [`AGE_BITS-1:0] max_age;
        next_lru = lru;
        max_age  = '0;
        if (hit || (state == FINISH)) begin
            for (int s = 0; s < `SETS_PER_BANK; s++) begin
                max_age = '0;
                next_lru[s].lru_way = '0;
                for (int w = 0; w < `NUM_WAYS; w++) begin
                    if ((hit && (req_set == s[`SET_BITS-1:0]) &&
                         (hit_way == w[`WAY_BITS-1:0])) ||
                        ((state == FINISH) && (victim_set == s[`SET_BITS-1:0]) &&
                         (victim_way == w[`WAY_BITS-1:0]))) begin
                        next_lru[s].age[w] = '0;
                    end else if (lru[s].age[w] != '1) begin
                        next_lru[s].age[w] = lru[s].age[w] + 1'b1;
                    end
                    if (next_lru[s].age[w] > max_age) begin
                        max_age = next_lru[s].age[w];
                        next_lru[s].lru_way = w[`WAY_BITS-1:0];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= START;
            count <= '0;
            sets  <= '0;
            lru   <= '0;
        end else begin
            state <= next_state;
            sets  <= next_sets;
            lru   <= next_lru;
            // The word counter wraps back to zero after each block.
            if (ram.complete) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_start) begin
            victim_set <= miss_set;
            victim_way <= lru[miss_set].lru_way;
            eject_buf  <= sets[miss_set][lru[miss_set].lru_way];
        end
        if ((state == BLOCK_PULL) && ram.complete) begin
            pull_buf[count] <= ram.rdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            START:        if (mshr.entry.valid) next_state = BLOCK_PULL;
            BLOCK_PULL:   if (last_done) begin
                next_state = (eject_buf.valid && eject_buf.dirty) ? VICTIM_EJECT : FINISH;
            end
            VICTIM_EJECT: if (last_done) next_state = FINISH;
            default:      next_state = START;
        endcase
    end

    always_comb begin
        ram.ren   = 1'b0;
        ram.wen   = 1'b0;
        ram.addr  = '0;
        ram.wdata = '0;
        case (state)
            BLOCK_PULL: begin
                ram.ren  = ram.grant;
                ram.addr = {mshr.entry.block_addr.cache_view.tag, miss_set, BANK_SEL, count,
                            `BYTE_BITS'(0)};
            end
            VICTIM_EJECT: begin
                ram.wen   = ram.grant;
                ram.addr  = {eject_buf.tag, victim_set, BANK_SEL, count, `BYTE_BITS'(0)};
                ram.wdata = eject_buf.block[count];
            end
            default: begin
            end
        endcase
    end

    assign ram.busy   = (state == BLOCK_PULL) || (state == VICTIM_EJECT);
    assign mshr.done  = (state == FINISH);
    assign done_valid = (state == FINISH);
    assign done       = '{uuid: mshr.entry.uuid};

endmodule

/* cache_ifs.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

interface mshr_if
    import mem_req_pkg::*;
();
    mshr_entry_t entry;
    logic        done;

    modport owner (output entry, input done);
    modport bank  (input entry, output done);
endinterface

// One bank's view of the shared word-wide memory port.
interface ram_if ();
    logic                   ren;
    logic                   wen;
    logic                   busy;
    logic [`ADDR_BITS-1:0]  addr;
    logic [`WORD_BITS-1:0]  wdata;
    logic [`WORD_BITS-1:0]  rdata;
    logic                   complete;
    logic                   grant;

    modport client (
        output ren, wen, busy, addr, wdata,
        input  rdata, complete, grant
    );
    modport arbiter (
        input  ren, wen, busy, addr, wdata,
        output rdata, complete, grant
    );
endinterface

/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry. Banks interleave on block address bits just above the word offset.
`define NUM_BANKS      2
`define SETS_PER_BANK  4
`define NUM_WAYS       2
`define BLOCK_WORDS    4
`define UUID_BITS      4

`define BANK_BITS      ($clog2(`NUM_BANKS))
`define SET_BITS       ($clog2(`SETS_PER_BANK))
`define WAY_BITS       ($clog2(`NUM_WAYS))
`define OFF_BITS       ($clog2(`BLOCK_WORDS))

`define WORD_BITS      32
`define ADDR_BITS      32
`define BYTE_BITS      2
`define TAG_BITS       (`ADDR_BITS - `SET_BITS - `BANK_BITS - `OFF_BITS - `BYTE_BITS)
`define AGE_BITS       4

`endif

/* cache_types_pkg.sv */
`include "cache_macros.svh"

package cache_types_pkg;

    // Address as seen by the bank router.
    typedef struct packed {
        logic [`TAG_BITS+`SET_BITS-1:0] tag;
        logic [`BANK_BITS-1:0]          bank;
        logic [`OFF_BITS-1:0]           offset;
        logic [`BYTE_BITS-1:0]          byte_sel;
    } route_fields_t;

    // Address as seen inside a bank.
    typedef struct packed {
        logic [`TAG_BITS-1:0]  tag;
        logic [`SET_BITS-1:0]  index;
        logic [`BANK_BITS-1:0] bank;
        logic [`OFF_BITS-1:0]  offset;
        logic [`BYTE_BITS-1:0] byte_sel;
    } cache_fields_t;

    typedef union packed {
        route_fields_t route_view;
        cache_fields_t cache_view;
    } addr_u;

    typedef struct packed {
        logic                                    valid;
        logic                                    dirty;
        logic [`TAG_BITS-1:0]                    tag;
        logic [`BLOCK_WORDS-1:0][`WORD_BITS-1:0] block;
    } cache_frame;

    typedef cache_frame [`NUM_WAYS-1:0] cache_set;

    typedef struct packed {
        logic [`NUM_WAYS-1:0][`AGE_BITS-1:0] age;
        logic [`WAY_BITS-1:0]                lru_way;
    } lru_frame;

    typedef enum logic [1:0] {
        START,
        BLOCK_PULL,
        VICTIM_EJECT,
        FINISH
    } bank_fsm_e;

endpackage

/* mem_req_pkg.sv */
`include "cache_macros.svh"

package mem_req_pkg;

    import cache_types_pkg::*;

    typedef struct packed {
        addr_u                  addr;
        logic                   store;
        logic [`WORD_BITS-1:0]  wdata;
        logic [`UUID_BITS-1:0]  uuid;
    } cache_req_t;

    // One outstanding miss. Stores that arrive while the block is pending are merged here.
    typedef struct packed {
        logic                                    valid;
        logic [`UUID_BITS-1:0]                   uuid;
        addr_u                                   block_addr;
        logic [`BLOCK_WORDS-1:0]                 write_status;
        logic [`BLOCK_WORDS-1:0][`WORD_BITS-1:0] write_block;
    } mshr_entry_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0] uuid;
    } completion_t;

endpackage

/* mshr_unit.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module mshr_unit
    import cache_types_pkg::*;
    import mem_req_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  cache_req_t req,
    input  logic       alloc,
    input  logic       merge,
    mshr_if.owner      mshr
);

    logic                                    valid_q;
    logic [`BLOCK_WORDS-1:0]                 status_q;
    logic [`UUID_BITS-1:0]                   uuid_q;
    addr_u                                   addr_q;
    logic [`BLOCK_WORDS-1:0][`WORD_BITS-1:0] block_q;

    // The bank never merges in FINISH, so the done pulse does not race a merge.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q  <= 1'b0;
            status_q <= '0;
        end else if (mshr.done) begin
            valid_q <= 1'b0;
        end else begin
            if (alloc) begin
                valid_q  <= 1'b1;
                status_q <= '0;
            end
            // A store that allocates also lands here, after the mask clear above.
            if (merge) begin
                status_q[req.addr.cache_view.offset] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (alloc) begin
            uuid_q <= req.uuid;
            addr_q <= req.addr;
        end
        if (merge) begin
            block_q[req.addr.cache_view.offset] <= req.wdata;
        end
    end

    assign mshr.entry = '{
        valid:        valid_q,
        uuid:         uuid_q,
        block_addr:   addr_q,
        write_status: status_q,
        write_block:  block_q
    };

endmodule

/* nonblocking_cache.f */
+incdir+.
cache_types_pkg.sv
mem_req_pkg.sv
cache_ifs.sv
mshr_unit.sv
cache_bank.sv
ram_arbiter.sv
nonblocking_cache.sv
tb_clock.sv
cache_assert.sv
tb_top.sv

/* nonblocking_cache.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module nonblocking_cache
    import cache_types_pkg::*;
    import mem_req_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    input  logic                  req_store,
    input  logic [`ADDR_BITS-1:0] req_addr,
    input  logic [`WORD_BITS-1:0] req_wdata,
    input  logic [`UUID_BITS-1:0] req_uuid,
    output logic                  req_ready,
    output logic                  resp_hit,
    output logic                  resp_miss,
    output logic                  resp_merged,
    output logic [`WORD_BITS-1:0] resp_data,
    output logic                  done_valid,
    output logic [`UUID_BITS-1:0] done_uuid,
    output logic                  mem_ren,
    output logic                  mem_wen,
    output logic [`ADDR_BITS-1:0] mem_addr,
    output logic [`WORD_BITS-1:0] mem_wdata,
    input  logic [`WORD_BITS-1:0] mem_rdata,
    input  logic                  mem_done
);

    addr_u                                  route_addr;
    cache_req_t                             req;
    logic [`NUM_BANKS-1:0]                  bank_valid, hit, merge, alloc, bank_done;
    logic [`NUM_BANKS-1:0][`WORD_BITS-1:0]  load_data;
    completion_t [`NUM_BANKS-1:0]           done_rec;

    mshr_if mshr_bus [`NUM_BANKS-1:0] ();
    ram_if  ram_bus  [`NUM_BANKS-1:0] ();

    assign route_addr = req_addr;
    assign req = '{addr: route_addr, store: req_store, wdata: req_wdata, uuid: req_uuid};

    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
        assign bank_valid[b] = req_valid && (route_addr.route_view.bank == b);

        mshr_unit u_mshr (
            .CLK   (CLK),
            .nRST  (nRST),
            .req   (req),
            .alloc (alloc[b]),
            .merge (merge[b]),
            .mshr  (mshr_bus[b])
        );

        cache_bank #(
            .BANK_ID (b)
        ) u_bank (
            .CLK        (CLK),
            .nRST       (nRST),
            .req_valid  (bank_valid[b]),
            .req        (req),
            .mshr       (mshr_bus[b]),
            .ram        (ram_bus[b]),
            .hit        (hit[b]),
            .merge_ok   (merge[b]),
            .alloc      (alloc[b]),
            .load_data  (load_data[b]),
            .done_valid (bank_done[b]),
            .done       (done_rec[b])
        );
    end

    ram_arbiter u_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .banks     (ram_bus),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_done  (mem_done)
    );

    // A request the routed bank can neither serve, merge nor allocate is held off.
    assign req_ready   = !(|(bank_valid & ~(hit | merge | alloc)));
    assign resp_hit    = |hit;
    assign resp_miss   = |alloc;
    assign resp_merged = |merge;

    // Completions are spaced by the arbiter, so lowest index wins only as a formality.
    always_comb begin
        resp_data  = '0;
        done_valid = 1'b0;
        done_uuid  = '0;
        for (int b = `NUM_BANKS - 1; b >= 0; b--) begin
            resp_data = resp_data | load_data[b];
            if (bank_done[b]) begin
                done_valid = 1'b1;
                done_uuid  = done_rec[b].uuid;
            end
        end
    end

endmodule

/* ram_arbiter.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module ram_arbiter (
    input  logic                  CLK,
    input  logic                  nRST,
    ram_if.arbiter                banks [`NUM_BANKS-1:0],
    output logic                  mem_ren,
    output logic                  mem_wen,
    output logic [`ADDR_BITS-1:0] mem_addr,
    output logic [`WORD_BITS-1:0] mem_wdata,
    input  logic [`WORD_BITS-1:0] mem_rdata,
    input  logic                  mem_done
);

    logic [`NUM_BANKS-1:0]                  busy, ren, wen, owned;
    logic [`NUM_BANKS-1:0][`ADDR_BITS-1:0]  addr;
    logic [`NUM_BANKS-1:0][`WORD_BITS-1:0]  wdata;
    logic                                   locked, pick_valid;
    logic [`BANK_BITS-1:0]                  owner, last, pick;

    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_port
        assign busy[i]  = banks[i].busy;
        assign ren[i]   = banks[i].ren;
        assign wen[i]   = banks[i].wen;
        assign addr[i]  = banks[i].addr;
        assign wdata[i] = banks[i].wdata;
        assign owned[i] = locked && (owner == i);

        assign banks[i].grant    = owned[i];
        assign banks[i].complete = owned[i] && mem_done;
        assign banks[i].rdata    = mem_rdata;
    end

    // Search starts just after the last owner, so the last owner has lowest priority.
    always_comb begin
        logic [`BANK_BITS-1:0] cand;
        pick       = last;
        pick_valid = 1'b0;
        cand       = last;
        for (int k = `NUM_BANKS; k >= 1; k--) begin
            cand = last + k[`BANK_BITS-1:0];
            if (busy[cand]) begin
                pick       = cand;
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            locked <= 1'b0;
            owner  <= '0;
            last   <= '1;
        end else if (locked) begin
            if (!busy[owner]) begin
                locked <= 1'b0;
                last   <= owner;
            end
        end else if (pick_valid) begin
            locked <= 1'b1;
            owner  <= pick;
        end
    end

    assign mem_ren   = locked && ren[owner];
    assign mem_wen   = locked && wen[owner];
    assign mem_addr  = addr[owner];
    assign mem_wdata = wdata[owner];

endmodule

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Reset is held for two rising edges and released on a falling edge.
    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

/* tb_top.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module tb_top;

    logic                  CLK, nRST;
    logic                  req_valid, req_store, req_ready;
    logic [`ADDR_BITS-1:0] req_addr, mem_addr;
    logic [`WORD_BITS-1:0] req_wdata, resp_data, mem_wdata, mem_rdata;
    logic [`UUID_BITS-1:0] req_uuid, done_uuid;
    logic                  resp_hit, resp_miss, resp_merged, done_valid;
    logic                  mem_ren, mem_wen, mem_done;

    logic [`WORD_BITS-1:0] mem [logic [`ADDR_BITS-1:0]];
    logic [`WORD_BITS-1:0] shadow [logic [`ADDR_BITS-1:0]];
    logic [`UUID_BITS-1:0] done_q [$];
    int                    seed = 12;
    int                    delay, mem_reads, mem_writes, errors, test_errors, tests;
    logic                  got_hit, got_miss, got_merged;
    logic [`WORD_BITS-1:0] got_data;

    tb_clock u_clock (.CLK(CLK), .nRST(nRST));

    nonblocking_cache dut (.*);

    function automatic logic [`WORD_BITS-1:0] fill_word(input logic [`ADDR_BITS-1:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_1234;
    endfunction

    function automatic logic [`WORD_BITS-1:0] expected_word(input logic [`ADDR_BITS-1:0] a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic logic [`ADDR_BITS-1:0] word_addr(input int tag, input int set,
                                                        input int bank, input int off);
        return {tag[24:0], set[1:0], bank[0], off[1:0], 2'b00};
    endfunction

    // Word memory with 0 to 3 wait cycles per access.
    always @(negedge CLK) begin
        if (!nRST) begin
            mem_done = 1'b0;
            delay    = 0;
        end else if (mem_done) begin
            mem_done = 1'b0;
        end else if (mem_ren || mem_wen) begin
            if (delay > 0) begin
                delay--;
            end else begin
                if (mem_ren) begin
                    mem_rdata = mem.exists(mem_addr) ? mem[mem_addr] : fill_word(mem_addr);
                    mem_reads++;
                end else begin
                    mem[mem_addr] = mem_wdata;
                    mem_writes++;
                end
                mem_done = 1'b1;
                delay    = $unsigned($random(seed)) % 4;
            end
        end
    end

    always @(negedge CLK) begin
        if (nRST && done_valid) done_q.push_back(done_uuid);
    end

    task automatic fail_count();
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string name, input logic [`WORD_BITS-1:0] got,
                              input logic [`WORD_BITS-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_count();
        end
    endtask

    task automatic check_uuid(input string name, input logic [`UUID_BITS-1:0] got,
                              input logic [`UUID_BITS-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            fail_count();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_count();
        end
    endtask

    // Called just after a falling edge. Fields are held until the cache takes them.
    task automatic send(input logic [`ADDR_BITS-1:0] addr, input logic store,
                        input logic [`WORD_BITS-1:0] wdata, input logic [`UUID_BITS-1:0] uuid);
        int   tries;
        logic accepted;
        tries    = 0;
        accepted = 1'b0;
        req_valid = 1'b1;
        req_store = store;
        req_addr  = addr;
        req_wdata = wdata;
        req_uuid  = uuid;
        while (!accepted && tries < 100) begin
            #10;
            if (req_ready) begin
                accepted   = 1'b1;
                got_hit    = resp_hit;
                got_miss   = resp_miss;
                got_merged = resp_merged;
                got_data   = resp_data;
            end
            @(negedge CLK);
            tries++;
        end
        req_valid = 1'b0;
        if (!accepted) begin
            $display("Request to address %h was never accepted", addr);
            fail_count();
        end else if (store) begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic expect_load(input logic [`ADDR_BITS-1:0] addr, input logic hit,
                               input logic [`UUID_BITS-1:0] uuid);
        send(addr, 1'b0, '0, uuid);
        check_flag("resp_hit", got_hit, hit);
        check_flag("resp_miss", got_miss, !hit);
        if (hit) check_word("resp_data", got_data, expected_word(addr));
    endtask

    task automatic wait_done(input logic [`UUID_BITS-1:0] uuid);
        int tries;
        tries = 0;
        while (done_q.size() == 0 && tries < 300) begin
            @(negedge CLK);
            tries++;
        end
        if (done_q.size() == 0) begin
            $display("No completion arrived for uuid %0d", uuid);
            fail_count();
        end else begin
            check_uuid("done_uuid", done_q.pop_front(), uuid);
        end
    endtask

    task automatic miss_fill(input logic [`ADDR_BITS-1:0] addr, input logic [`UUID_BITS-1:0] uuid);
        expect_load(addr, 1'b0, uuid);
        wait_done(uuid);
    endtask

    task automatic compare_memory_block(input logic [`ADDR_BITS-1:0] base);
        for (int k = 0; k < `BLOCK_WORDS; k++) begin
            check_word("memory word", mem.exists(base + 4 * k) ? mem[base + 4 * k] :
                       fill_word(base + 4 * k), expected_word(base + 4 * k));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) $display("%s: ok", name);
        else $display("%s: %0d failed checks", name, test_errors);
        test_errors = 0;
    endtask

    task automatic after_reset();
        check_flag("req_ready", req_ready, 1'b1);
        check_flag("resp_hit", resp_hit, 1'b0);
        check_flag("resp_miss", resp_miss, 1'b0);
        check_flag("resp_merged", resp_merged, 1'b0);
        check_flag("done_valid", done_valid, 1'b0);
        check_flag("mem_ren", mem_ren, 1'b0);
        check_flag("mem_wen", mem_wen, 1'b0);
        end_test("reset");
    endtask

    task automatic cold_miss();
        int reads;
        reads = mem_reads;
        expect_load(word_addr(1, 0, 0, 2), 1'b0, 4'd1);
        wait_done(4'd1);
        check_word("block reads", mem_reads - reads, `BLOCK_WORDS);
        expect_load(word_addr(1, 0, 0, 2), 1'b1, 4'd2);
        end_test("cold miss");
    endtask

    task automatic store_write_back();
        int writes;
        send(word_addr(1, 0, 0, 1), 1'b1, 32'hCAFE_0001, 4'd3);
        check_flag("resp_hit", got_hit, 1'b1);
        writes = mem_writes;
        miss_fill(word_addr(2, 0, 0, 0), 4'd4);
        miss_fill(word_addr(3, 0, 0, 0), 4'd5);
        check_word("write-back words", mem_writes - writes, `BLOCK_WORDS);
        compare_memory_block(word_addr(1, 0, 0, 0));
        end_test("store and write-back");
    endtask

    task automatic merge_pending();
        int writes;
        expect_load(word_addr(1, 1, 0, 0), 1'b0, 4'd6);
        send(word_addr(1, 1, 0, 3), 1'b1, 32'hBEEF_0003, 4'd7);
        check_flag("resp_merged", got_merged, 1'b1);
        check_flag("resp_miss", got_miss, 1'b0);
        wait_done(4'd6);
        expect_load(word_addr(1, 1, 0, 3), 1'b1, 4'd7);
        expect_load(word_addr(1, 1, 0, 0), 1'b1, 4'd7);
        writes = mem_writes;
        miss_fill(word_addr(2, 1, 0, 0), 4'd8);
        miss_fill(word_addr(3, 1, 0, 0), 4'd9);
        check_word("write-back words", mem_writes - writes, `BLOCK_WORDS);
        compare_memory_block(word_addr(1, 1, 0, 0));
        end_test("merge into pending miss");
    endtask

    task automatic lru_order();
        int writes;
        miss_fill(word_addr(1, 2, 0, 0), 4'd1);
        expect_load(word_addr(1, 2, 0, 1), 1'b1, 4'd1);
        miss_fill(word_addr(2, 2, 0, 0), 4'd2);
        expect_load(word_addr(1, 2, 0, 2), 1'b1, 4'd2);
        writes = mem_writes;
        miss_fill(word_addr(3, 2, 0, 0), 4'd3);
        check_word("clean eviction writes", mem_writes - writes, 0);
        expect_load(word_addr(1, 2, 0, 3), 1'b1, 4'd4);
        miss_fill(word_addr(2, 2, 0, 1), 4'd5);
        end_test("LRU");
    endtask

    task automatic two_bank_misses();
        int reads;
        reads = mem_reads;
        expect_load(word_addr(1, 3, 0, 0), 1'b0, 4'd8);
        expect_load(word_addr(1, 3, 1, 0), 1'b0, 4'd9);
        req_valid = 1'b1;
        req_store = 1'b0;
        req_addr  = word_addr(2, 3, 0, 0);
        #10;
        check_flag("req_ready on busy bank", req_ready, 1'b0);
        @(negedge CLK);
        expect_load(word_addr(2, 3, 0, 0), 1'b0, 4'd10);
        check_flag("busy bank completed first", done_q.size() > 0, 1'b1);
        wait_done(4'd8);
        wait_done(4'd9);
        wait_done(4'd10);
        check_word("block reads", mem_reads - reads, 3 * `BLOCK_WORDS);
        expect_load(word_addr(1, 3, 1, 2), 1'b1, 4'd11);
        end_test("two banks");
    endtask

    initial begin
        int tries;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_uuid  = '0;
        mem_done  = 1'b0;
        mem_rdata = '0;
        errors    = 0;
        tries     = 0;
        while (nRST !== 1'b1 && tries < 10) begin
            @(negedge CLK);
            tries++;
        end
        after_reset();
        cold_miss();
        store_write_back();
        merge_pending();
        lru_order();
        two_bank_misses();
        $display("Tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #500000;
        $display("Simulation ran past its time limit");
        $display("Finished with errors");
        $finish;
    end

endmodule
